// File: miner_cfg.svh
`ifndef MINER_CFG_SVH
`define MINER_CFG_SVH

`define MINER_SCREEN_W     320      // Frame buffer width
`define MINER_SCREEN_H     240
`define MINER_HOOK_SIZE    4        // Hook side, also one descent step
`define MINER_ROPE_TOP     16       // Hook row at round start
`define MINER_GOLD_SIZE    8
`define MINER_NUM_GOLD     4

// Nugget corners, rows kept on the 4-pixel hook grid
`define MINER_GOLD0_X      40
`define MINER_GOLD0_Y      120
`define MINER_GOLD1_X      120
`define MINER_GOLD1_Y      160
`define MINER_GOLD2_X      200
`define MINER_GOLD2_Y      96
`define MINER_GOLD3_X      272
`define MINER_GOLD3_Y      200

`define MINER_GOLD0_VAL    50       // Score per nugget
`define MINER_GOLD1_VAL    100
`define MINER_GOLD2_VAL    150
`define MINER_GOLD3_VAL    250

`define MINER_STEP_CYCLES  30       // Cycles between hook steps

`define MINER_COL_GOLD     12'hFD0
`define MINER_COL_HOOK     12'hAAA
`define MINER_COL_BG       12'h000  // Black background

`endif

// File: miner_pkg.sv
`default_nettype none

package miner_pkg;

	typedef logic [8:0]  coord_t;   // Screen x or y
	typedef logic [11:0] colour_t;  // R, G, B at 4 bits each
	typedef logic [9:0]  score_t;   // Shown on LEDR

	// One frame buffer write
	typedef struct packed {
		coord_t  x;
		coord_t  y;
		colour_t colour;
	} pixel_t;

	// Filled rectangle request
	typedef struct packed {
		coord_t  x;       // Top left corner
		coord_t  y;
		coord_t  w;       // Width, at least 1
		coord_t  h;
		colour_t colour;
	} rect_t;

	typedef enum logic [2:0] {
		INIT_GOLD,        // Paint nuggets after reset
		IDLE,
		DRAW_HOOK,
		WAIT_STEP,
		ERASE_HOOK,
		CHECK,            // Hit test at new row
		ERASE_GOLD,
		NEXT              // Hit result valid here
	} miner_state_e;

endpackage

`default_nettype wire

// File: rect_filler.sv
`timescale 1ns/1ps
`default_nettype none

module rect_filler (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              rect_start,  // One-cycle fill request
	input  miner_pkg::rect_t  rect_req,
	output logic              plot,        // Pixel write strobe
	output miner_pkg::pixel_t pixel,
	output logic              rect_done    // With the last pixel
);
	import miner_pkg::*;

	rect_t  req_q;      // Latched request
	coord_t col_q;      // Offset inside the row
	coord_t row_q;      // Offset inside the column
	logic   busy_q;     // Fill in progress
	logic   last_col;
	logic   last_row;

	assign last_col = (col_q == req_q.w - coord_t'(1));
	assign last_row = (row_q == req_q.h - coord_t'(1));

	// Raster walk, x runs fastest
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			col_q  <= '0;
			row_q  <= '0;
		end else if (rect_start) begin
			busy_q <= 1'b1;              // First pixel next cycle
			col_q  <= '0;
			row_q  <= '0;
		end else if (busy_q) begin
			if (last_col) begin
				col_q <= '0;
				row_q <= row_q + coord_t'(1);
				if (last_row) begin
					busy_q <= 1'b0;      // Whole rectangle out
				end
			end else begin
				col_q <= col_q + coord_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rect_start) begin
			req_q <= rect_req;           // Hold corner, size, colour
		end
	end

	assign plot         = busy_q;
	assign pixel.x      = req_q.x + col_q;
	assign pixel.y      = req_q.y + row_q;
	assign pixel.colour = req_q.colour;
	assign rect_done    = busy_q && last_col && last_row;

	// Controller waits for rect_done before the next request
	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
		busy_q |-> !rect_start)
		else $error("rect_start while a fill is in progress");

	// Zero size would wrap the counters and flood the frame buffer
	a_size_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		rect_start |-> (rect_req.w != '0 && rect_req.h != '0))
		else $error("fill request with zero width or height");

endmodule

`default_nettype wire

// File: drop_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "miner_cfg.svh"

module drop_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic step_en,   // Level, high while the hook waits
	output logic step       // One-cycle tick
);

	localparam int CNT_W = $clog2(`MINER_STEP_CYCLES);
	localparam logic [CNT_W-1:0] CNT_END = CNT_W'(`MINER_STEP_CYCLES - 1);

	logic [CNT_W-1:0] cnt_q;   // Cycles since enable or last tick

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_q <= '0;
			step  <= 1'b0;
		end else if (!step_en) begin
			cnt_q <= '0;               // Restart on every enable
			step  <= 1'b0;
		end else if (cnt_q == CNT_END) begin
			cnt_q <= '0;               // Wrap and tick
			step  <= 1'b1;
		end else begin
			cnt_q <= cnt_q + CNT_W'(1);
			step  <= 1'b0;
		end
	end

	// FSM holds step_en until it has seen the tick
	a_step_enabled: assert property (@(posedge clk) disable iff (!rst_n)
		step |-> step_en)
		else $error("step pulse with step_en low");

endmodule

`default_nettype wire

// File: gold_field.sv
`timescale 1ns/1ps
`default_nettype none

`include "miner_cfg.svh"

module gold_field (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [1:0]        gold_sel,   // Nugget index for the initial paint
	input  miner_pkg::rect_t  hook_rect,
	input  logic              check,      // Hit test strobe
	output miner_pkg::rect_t  gold_rect,
	output logic              hit,        // Cycle after check
	output miner_pkg::rect_t  hit_rect,
	output miner_pkg::score_t ledr
);
	import miner_pkg::*;

	localparam int NG = `MINER_NUM_GOLD;
	localparam coord_t GOLD_X [NG] = '{`MINER_GOLD0_X, `MINER_GOLD1_X,
		`MINER_GOLD2_X, `MINER_GOLD3_X};
	localparam coord_t GOLD_Y [NG] = '{`MINER_GOLD0_Y, `MINER_GOLD1_Y,
		`MINER_GOLD2_Y, `MINER_GOLD3_Y};
	localparam score_t GOLD_VAL [NG] = '{`MINER_GOLD0_VAL, `MINER_GOLD1_VAL,
		`MINER_GOLD2_VAL, `MINER_GOLD3_VAL};
	localparam logic [9:0] GS = 10'(`MINER_GOLD_SIZE);   // Extra bit for span ends

	rect_t         gold_tab [NG];   // Nugget squares in gold
	logic [NG-1:0] collected_q;
	logic [9:0]    hx_end;          // Hook span, exclusive end
	logic [9:0]    hy_end;
	logic          hit_any;
	logic [1:0]    hit_idx;         // Lowest overlapping nugget
	logic [10:0]   score_sum;       // Carry flags saturation

	always_comb begin
		for (int i = 0; i < NG; i++) begin
			gold_tab[i] = '{x: GOLD_X[i], y: GOLD_Y[i], w: coord_t'(GS), h: coord_t'(GS),
				colour: `MINER_COL_GOLD};
		end
	end

	assign gold_rect = gold_tab[gold_sel];
	assign hx_end    = {1'b0, hook_rect.x} + {1'b0, hook_rect.w};
	assign hy_end    = {1'b0, hook_rect.y} + {1'b0, hook_rect.h};

	// Overlap on both axes, collected nuggets skipped
	always_comb begin
		hit_any = 1'b0;
		hit_idx = '0;
		for (int i = 0; i < NG; i++) begin
			if (!hit_any && !collected_q[i]
				&& ({1'b0, GOLD_X[i]} < hx_end) && ({1'b0, hook_rect.x} < GOLD_X[i] + GS)
				&& ({1'b0, GOLD_Y[i]} < hy_end) && ({1'b0, hook_rect.y} < GOLD_Y[i] + GS)) begin
				hit_any = 1'b1;
				hit_idx = 2'(i);
			end
		end
	end

	assign score_sum = {1'b0, ledr} + {1'b0, GOLD_VAL[hit_idx]};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			collected_q <= '0;
			ledr        <= '0;
			hit         <= 1'b0;
		end else begin
			hit <= check && hit_any;
			if (check && hit_any) begin
				collected_q[hit_idx] <= 1'b1;
				ledr <= score_sum[10] ? '1 : score_sum[9:0];   // Clamp at 1023
			end
		end
	end

	always_ff @(posedge clk) begin
		if (check && hit_any) begin
			hit_rect <= gold_tab[hit_idx];   // Square to erase
		end
	end

	a_score_mono: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> (ledr >= $past(ledr)))
		else $error("score decreased");

endmodule

`default_nettype wire

// File: miner_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "miner_cfg.svh"

module miner_fsm (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               go,           // Round start, IDLE only
	input  miner_pkg::coord_t  position_in,  // Hook column
	input  logic               rect_done,
	input  logic               step,
	input  logic               hit,
	input  miner_pkg::rect_t   gold_rect,
	input  miner_pkg::rect_t   hit_rect,
	output logic               rect_start,
	output miner_pkg::rect_t   rect_req,
	output logic               step_en,
	output logic [1:0]         gold_sel,
	output miner_pkg::rect_t   hook_rect,
	output logic               check
);
	import miner_pkg::*;

	localparam coord_t HOOK      = coord_t'(`MINER_HOOK_SIZE);
	localparam coord_t X_MAX     = coord_t'(`MINER_SCREEN_W - `MINER_HOOK_SIZE);
	localparam coord_t ROPE_TOP  = coord_t'(`MINER_ROPE_TOP);
	localparam logic [1:0] SEL_LAST = 2'(`MINER_NUM_GOLD - 1);
	localparam logic [9:0] Y_LIMIT  = 10'(`MINER_SCREEN_H);

	miner_state_e state_q;
	coord_t       hook_x_q;
	coord_t       hook_y_q;
	logic         fill_busy_q;   // Request out, waiting for rect_done
	logic         fill_state;    // Current state paints a rectangle
	rect_t        fill_rect;
	logic [9:0]   hook_bottom;   // Exclusive bottom row of the hook

	assign step_en     = (state_q == WAIT_STEP);
	assign check       = (state_q == CHECK);
	assign hook_rect   = '{x: hook_x_q, y: hook_y_q, w: HOOK, h: HOOK,
		colour: `MINER_COL_HOOK};
	assign hook_bottom = {1'b0, hook_y_q} + {1'b0, HOOK};

	// Rectangle for each painting state
	always_comb begin
		fill_state = 1'b1;
		fill_rect  = hook_rect;
		case (state_q)
			INIT_GOLD:  fill_rect = gold_rect;
			DRAW_HOOK:  fill_rect = hook_rect;
			ERASE_HOOK: fill_rect.colour = `MINER_COL_BG;
			ERASE_GOLD: begin
				fill_rect        = hit_rect;
				fill_rect.colour = `MINER_COL_BG;   // Nugget taken
			end
			default:    fill_state = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q     <= INIT_GOLD;
			gold_sel    <= '0;
			fill_busy_q <= 1'b0;
			rect_start  <= 1'b0;
			hook_x_q    <= '0;
			hook_y_q    <= ROPE_TOP;
		end else begin
			rect_start <= 1'b0;
			if (fill_state && !fill_busy_q) begin
				rect_start  <= 1'b1;             // One request per state visit
				fill_busy_q <= 1'b1;
			end
			if (rect_done) begin
				fill_busy_q <= 1'b0;
			end
			case (state_q)
				INIT_GOLD: begin
					if (rect_done) begin
						if (gold_sel == SEL_LAST) begin
							state_q <= IDLE;
						end else begin
							gold_sel <= gold_sel + 2'd1;   // Next nugget
						end
					end
				end
				IDLE: begin
					if (go) begin
						hook_x_q <= (position_in > X_MAX) ? X_MAX : position_in;
						hook_y_q <= ROPE_TOP;
						state_q  <= DRAW_HOOK;
					end
				end
				DRAW_HOOK: begin
					if (rect_done) begin
						state_q <= WAIT_STEP;
					end
				end
				WAIT_STEP: begin
					if (step) begin
						state_q <= ERASE_HOOK;
					end
				end
				ERASE_HOOK: begin
					if (rect_done) begin
						hook_y_q <= hook_y_q + HOOK;   // Descend one square
						state_q  <= CHECK;
					end
				end
				CHECK: state_q <= NEXT;
				NEXT: begin
					if (hit) begin
						state_q <= ERASE_GOLD;
					end else if (hook_bottom > Y_LIMIT) begin
						state_q <= IDLE;                // Past the bottom edge
					end else begin
						state_q <= DRAW_HOOK;
					end
				end
				ERASE_GOLD: begin
					if (rect_done) begin
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fill_state && !fill_busy_q) begin
			rect_req <= fill_rect;
		end
	end

	// Hit result lands exactly where the FSM samples it
	a_hit_in_next: assert property (@(posedge clk) disable iff (!rst_n)
		hit |-> (state_q == NEXT))
		else $error("hit outside NEXT");

endmodule

`default_nettype wire

// File: gold_miner.sv
`timescale 1ns/1ps
`default_nettype none

module gold_miner (
	input  logic               CLOCK_50,     // 50 MHz board clock
	input  logic               rst_n,
	input  logic               go,
	input  miner_pkg::coord_t  position_in,  // Hook column from switches
	output logic               plot,         // To frame buffer adapter
	output miner_pkg::pixel_t  pixel,
	output miner_pkg::score_t  ledr
);
	import miner_pkg::*;

	rect_t      rect_req;
	rect_t      gold_rect;
	rect_t      hit_rect;
	rect_t      hook_rect;
	logic       rect_start;
	logic       rect_done;
	logic       step_en;
	logic       step;
	logic       check;
	logic       hit;
	logic [1:0] gold_sel;

	miner_fsm u_fsm (
		.clk(CLOCK_50), .rst_n(rst_n), .go(go), .position_in(position_in),
		.rect_done(rect_done), .step(step), .hit(hit),
		.gold_rect(gold_rect), .hit_rect(hit_rect),
		.rect_start(rect_start), .rect_req(rect_req), .step_en(step_en),
		.gold_sel(gold_sel), .hook_rect(hook_rect), .check(check)
	);

	drop_timer u_timer (
		.clk(CLOCK_50), .rst_n(rst_n), .step_en(step_en), .step(step)
	);

	gold_field u_gold (
		.clk(CLOCK_50), .rst_n(rst_n), .gold_sel(gold_sel), .hook_rect(hook_rect),
		.check(check), .gold_rect(gold_rect), .hit(hit), .hit_rect(hit_rect),
		.ledr(ledr)
	);

	rect_filler u_fill (
		.clk(CLOCK_50), .rst_n(rst_n), .rect_start(rect_start), .rect_req(rect_req),
		.plot(plot), .pixel(pixel), .rect_done(rect_done)
	);

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD = 10;   // 20 ns clock
	localparam int RESET_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;                  // Release on a rising edge
	end

endmodule

`default_nettype wire

// File: tb_gold_miner.sv
`timescale 1ns/1ps
`default_nettype none

`include "miner_cfg.svh"

module tb_gold_miner;
	import miner_pkg::*;

	localparam int HOOK = `MINER_HOOK_SIZE;
	localparam int GSZ = `MINER_GOLD_SIZE;
	localparam int X_LIM = `MINER_SCREEN_W - `MINER_HOOK_SIZE;   // Rightmost hook column
	localparam int MAX_STEPS = (`MINER_SCREEN_H - `MINER_ROPE_TOP) / HOOK;
	localparam int INIT_CYCLES = `MINER_NUM_GOLD * (GSZ * GSZ + 4) + 8;
	localparam int NUM_ROUNDS = 5;
	localparam int TIMEOUT_CYCLES =
		2 * (NUM_ROUNDS * MAX_STEPS * (`MINER_STEP_CYCLES + 40) + INIT_CYCLES);
	localparam int NO_HIT = 4;
	localparam int GOLD_X [4] = '{`MINER_GOLD0_X, `MINER_GOLD1_X, `MINER_GOLD2_X,
		`MINER_GOLD3_X};
	localparam int GOLD_Y [4] = '{`MINER_GOLD0_Y, `MINER_GOLD1_Y, `MINER_GOLD2_Y,
		`MINER_GOLD3_Y};
	localparam int GOLD_VAL [4] = '{`MINER_GOLD0_VAL, `MINER_GOLD1_VAL, `MINER_GOLD2_VAL,
		`MINER_GOLD3_VAL};

	typedef struct packed {
		logic [8:0] col;      // Hook column given with go
		logic [2:0] hit;      // Expected nugget, 4 for none
		logic       mid_go;   // Extra go while the hook drops
	} round_t;

	localparam round_t ROUNDS [NUM_ROUNDS] = '{
		'{col: 9'd8,   hit: 3'd4, mid_go: 1'b0},   // Clear column to the bottom
		'{col: 9'd122, hit: 3'd1, mid_go: 1'b0},   // Lands on nugget 1
		'{col: 9'd122, hit: 3'd4, mid_go: 1'b0},   // Nugget 1 already taken
		'{col: 9'd400, hit: 3'd4, mid_go: 1'b0},   // Clamped to the right edge
		'{col: 9'd202, hit: 3'd2, mid_go: 1'b1}    // Second go must be ignored
	};

	logic   clk;
	logic   rst_n;
	logic   go;
	coord_t position_in;
	logic   plot;
	pixel_t pixel;
	score_t ledr;

	pixel_t     exp_q [$];         // Expected pixel stream
	logic [3:0] collected = '0;    // Model nugget flags
	int         exp_score = 0;
	int         err_cnt = 0;
	int         pass_cnt = 0;
	int         fail_cnt = 0;
	int         plotted = 0;

	tb_clock u_clock (.clk(clk), .rst_n(rst_n));

	gold_miner UUT (
		.CLOCK_50(clk), .rst_n(rst_n), .go(go), .position_in(position_in),
		.plot(plot), .pixel(pixel), .ledr(ledr)
	);

	task automatic check_pixel(input pixel_t exp_p, input pixel_t act_p);
		if (act_p !== exp_p) begin
			$display("FAIL pixel: expected 0x%h, actual 0x%h", exp_p, act_p);
			err_cnt++;
		end
	endtask

	task automatic check_score(input score_t exp_s, input score_t act_s);
		if (act_s !== exp_s) begin
			$display("FAIL ledr: expected 0x%h, actual 0x%h", exp_s, act_s);
			err_cnt++;
		end
	endtask

	// Raster order, x fastest
	task automatic push_rect(input int x, input int y, input int w, input int h,
		input colour_t c);
		pixel_t p;
		for (int r = 0; r < h; r++) begin
			for (int k = 0; k < w; k++) begin
				p.x      = coord_t'(x + k);
				p.y      = coord_t'(y + r);
				p.colour = c;
				exp_q.push_back(p);
			end
		end
	endtask

	// One round of the hook from the top row down
	task automatic model_round(input int col, output int hit);
		int  x;
		int  y;
		bit  done;
		hit  = NO_HIT;
		done = 1'b0;
		x    = (col > X_LIM) ? X_LIM : col;
		y    = `MINER_ROPE_TOP;
		while (!done) begin
			push_rect(x, y, HOOK, HOOK, `MINER_COL_HOOK);
			push_rect(x, y, HOOK, HOOK, `MINER_COL_BG);   // Erase before moving
			y += HOOK;
			for (int g = 0; g < `MINER_NUM_GOLD; g++) begin
				if (hit == NO_HIT && !collected[g]
					&& x < GOLD_X[g] + GSZ && GOLD_X[g] < x + HOOK
					&& y < GOLD_Y[g] + GSZ && GOLD_Y[g] < y + HOOK) begin
					hit = g;                              // Lowest index wins
				end
			end
			if (hit != NO_HIT) begin
				collected[hit] = 1'b1;
				push_rect(GOLD_X[hit], GOLD_Y[hit], GSZ, GSZ, `MINER_COL_BG);
				done = 1'b1;
			end else if (y + HOOK > `MINER_SCREEN_H) begin
				done = 1'b1;                              // Bottom edge reached
			end
		end
	endtask

	task automatic pulse_go(input coord_t col);
		@(posedge clk);
		go          <= 1'b1;
		position_in <= col;
		@(posedge clk);
		go          <= 1'b0;
	endtask

	// All expected pixels out and FSM back in IDLE
	task automatic wait_round_done();
		do begin
			@(posedge clk);
		end while (exp_q.size() != 0 || UUT.u_fsm.state_q != IDLE);
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			pass_cnt++;
			$display("Test %s: passed", name);
		end else begin
			fail_cnt++;
			$display("Test %s: failed with %0d errors", name, err_cnt - errs_before);
		end
	endtask

	// Outputs sampled mid-cycle
	always @(negedge clk) begin : monitor
		pixel_t exp_p;
		if (rst_n && plot) begin
			if (exp_q.size() == 0) begin
				$display("Pixel written at x %0d y %0d when none was expected",
					pixel.x, pixel.y);
				err_cnt++;
			end else begin
				exp_p = exp_q.pop_front();
				check_pixel(exp_p, pixel);
				plotted++;
			end
		end
	end

	initial begin : watchdog
		int unsigned cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the pixel stream never finished", cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin : main
		int errs;
		int model_hit;
		int start;
		go          = 1'b0;
		position_in = '0;
		for (int g = 0; g < `MINER_NUM_GOLD; g++) begin
			push_rect(GOLD_X[g], GOLD_Y[g], GSZ, GSZ, `MINER_COL_GOLD);
		end
		errs = err_cnt;
		wait_round_done();
		check_score(score_t'(0), ledr);
		report_test("initial nugget paint", errs);
		for (int r = 0; r < NUM_ROUNDS; r++) begin
			errs = err_cnt;
			model_round(int'(ROUNDS[r].col), model_hit);
			if (model_hit != int'(ROUNDS[r].hit)) begin
				$display("Round %0d table expects nugget %0d but the model hits %0d",
					r, ROUNDS[r].hit, model_hit);
				err_cnt++;
			end
			if (int'(ROUNDS[r].hit) != NO_HIT) begin
				exp_score += GOLD_VAL[ROUNDS[r].hit];
				if (exp_score > 1023) begin
					exp_score = 1023;                     // LED score saturates
				end
			end
			pulse_go(ROUNDS[r].col);
			if (ROUNDS[r].mid_go) begin
				start = plotted;
				while (plotted < start + 20) begin
					@(posedge clk);
				end
				pulse_go(9'd8);                           // Hook already dropping
			end
			wait_round_done();
			check_score(score_t'(exp_score), ledr);
			report_test($sformatf("round %0d column %0d", r, ROUNDS[r].col), errs);
		end
		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
miner_pkg.sv
rect_filler.sv
drop_timer.sv
gold_field.sv
miner_fsm.sv
gold_miner.sv
tb_clock.sv
tb_gold_miner.sv

// File: Makefile
SIM = obj_dir/Vtb_gold_miner

.PHONY: all run lint clean

all: run

$(SIM): build.f *.sv *.svh
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f build.f --top-module tb_gold_miner

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps +incdir+. miner_pkg.sv \
		rect_filler.sv drop_timer.sv gold_field.sv miner_fsm.sv gold_miner.sv \
		--top-module gold_miner

clean:
	rm -rf obj_dir sim.log
